/* verilog/brew_pkg.sv */
// ==================================================
// Shared constants for the brew machine controller
// State codes 0 to 9 fit in STATE_W bits
// Dwell limits are short cycle counts for simulation
// and must be scaled up for a real clock rate
// ==================================================
`default_nettype none

package brew_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int STATE_W = 4;
    localparam int MENU_W  = 4;
    localparam int TEMP_W  = 2;
    localparam int TIMER_W = 16;

    // ==================================================
    // Controller state codes
    // ==================================================
    localparam logic [STATE_W-1:0] ST_INIT      = 4'd0;
    localparam logic [STATE_W-1:0] ST_IDLE      = 4'd1;
    localparam logic [STATE_W-1:0] ST_HEATING   = 4'd2;
    localparam logic [STATE_W-1:0] ST_READY     = 4'd3;
    localparam logic [STATE_W-1:0] ST_VALIDATE  = 4'd4;
    localparam logic [STATE_W-1:0] ST_BREWING   = 4'd5;
    localparam logic [STATE_W-1:0] ST_COMPLETE  = 4'd6;
    localparam logic [STATE_W-1:0] ST_ERROR     = 4'd7;
    localparam logic [STATE_W-1:0] ST_EMERGENCY = 4'd8;
    localparam logic [STATE_W-1:0] ST_COOLDOWN  = 4'd9;

    // ==================================================
    // Menu screens seen by the controller
    // ==================================================
    // Codes match the menu navigator encoding
    localparam logic [MENU_W-1:0] MENU_SPLASH   = 4'd0;
    localparam logic [MENU_W-1:0] MENU_BREWING  = 4'd6;
    localparam logic [MENU_W-1:0] MENU_COMPLETE = 4'd7;

    // Target temperature modes for the water controller
    localparam logic [TEMP_W-1:0] TEMP_STANDBY = 2'b00;
    localparam logic [TEMP_W-1:0] TEMP_BREWING = 2'b01;

    // ==================================================
    // Dwell limits in clock cycles
    // ==================================================
    // Time spent in init before idle
    localparam logic [TIMER_W-1:0] INIT_CYCLES     = 16'd16;
    // Cooldown length, also ready inactivity on splash
    localparam logic [TIMER_W-1:0] COOLDOWN_CYCLES = 16'd32;
    // Auto-return from completion screen
    localparam logic [TIMER_W-1:0] COMPLETE_CYCLES = 16'(2 * COOLDOWN_CYCLES);
    // Retry delay in error and emergency
    localparam logic [TIMER_W-1:0] RETRY_CYCLES    = 16'd40;

endpackage

`default_nettype wire

/* verilog/dwell_flags_if.sv */
// ==================================================
// Dwell-limit flags from timer to sequencer
// Plain levels, valid every cycle, no handshake
// ==================================================
`default_nettype none

interface dwell_flags_if;

    // Init dwell reached
    logic init_done;
    // Cooldown or ready inactivity reached
    logic cooldown_done;
    // Completion auto-return reached
    logic complete_done;
    // Error or emergency retry delay reached
    logic retry_done;

    modport timer (output init_done, cooldown_done, complete_done, retry_done);
    modport sequencer (input init_done, cooldown_done, complete_done, retry_done);

endinterface

`default_nettype wire

/* verilog/brew_sequencer.sv */
// ==================================================
// Controller state register and transition rules
// State changes on the edge after the causing inputs
// entered is high in the first cycle of each visit,
// but not in the first init cycle after reset
// ==================================================
`default_nettype none

module brew_sequencer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [brew_pkg::MENU_W-1:0]  menu_state,
    input  wire                          start_brewing_cmd,
    input  wire                          recipe_active,
    input  wire                          recipe_complete,
    input  wire                          recipe_valid,
    input  wire                          water_system_ok,
    input  wire                          can_make_coffee,
    input  wire                          paper_filter_present,
    input  wire                          critical_error,
    dwell_flags_if.sequencer             flags,
    output logic [brew_pkg::STATE_W-1:0] state,
    output logic [brew_pkg::STATE_W-1:0] next_state,
    output logic                         entered
);

    logic [brew_pkg::STATE_W-1:0] prev_state;
    // Recipe engine was started in this brewing visit
    logic                         brew_started;
    logic                         on_splash;
    logic                         checks_ok;

    // ==================================================
    // State and previous-state registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= brew_pkg::ST_INIT;
            prev_state <= brew_pkg::ST_INIT;
        end else begin
            prev_state <= state;
            state      <= next_state;
        end
    end

    assign entered = (state != prev_state);

    // Set on brewing entry, cleared once back in a calm state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brew_started <= 1'b0;
        end else if (state == brew_pkg::ST_BREWING && entered) begin
            brew_started <= 1'b1;
        end else if (state == brew_pkg::ST_IDLE || state == brew_pkg::ST_HEATING ||
                     state == brew_pkg::ST_READY) begin
            brew_started <= 1'b0;
        end
    end

    assign on_splash = (menu_state == brew_pkg::MENU_SPLASH);

    // Pre-brew checks
    assign checks_ok = recipe_valid && can_make_coffee && paper_filter_present &&
                       water_system_ok && !critical_error;

    // ==================================================
    // Next-state rules
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            brew_pkg::ST_INIT: begin
                if (flags.init_done) next_state = brew_pkg::ST_IDLE;
            end
            brew_pkg::ST_IDLE: begin
                if (critical_error) next_state = brew_pkg::ST_ERROR;
                else if (!on_splash) next_state = brew_pkg::ST_HEATING;
            end
            brew_pkg::ST_HEATING: begin
                if (critical_error) next_state = brew_pkg::ST_ERROR;
                else if (water_system_ok) next_state = brew_pkg::ST_READY;
                else if (on_splash) next_state = brew_pkg::ST_COOLDOWN;
            end
            brew_pkg::ST_READY: begin
                if (critical_error) begin
                    next_state = brew_pkg::ST_ERROR;
                end else if (start_brewing_cmd) begin
                    next_state = brew_pkg::ST_VALIDATE;
                end else if (on_splash) begin
                    // Idle on splash long enough, wind down
                    if (flags.cooldown_done) next_state = brew_pkg::ST_COOLDOWN;
                end else if (!water_system_ok) begin
                    next_state = brew_pkg::ST_HEATING;
                end
            end
            brew_pkg::ST_VALIDATE: begin
                next_state = checks_ok ? brew_pkg::ST_BREWING : brew_pkg::ST_ERROR;
            end
            brew_pkg::ST_BREWING: begin
                if (critical_error) next_state = brew_pkg::ST_EMERGENCY;
                else if (recipe_complete) next_state = brew_pkg::ST_COMPLETE;
                // Recipe engine dropped out on its own
                else if (!recipe_active && brew_started) next_state = brew_pkg::ST_ERROR;
                // User left the brewing screen
                else if (menu_state != brew_pkg::MENU_BREWING) next_state = brew_pkg::ST_READY;
            end
            brew_pkg::ST_COMPLETE: begin
                if (critical_error) begin
                    next_state = brew_pkg::ST_ERROR;
                end else if (menu_state != brew_pkg::MENU_COMPLETE || flags.complete_done) begin
                    next_state = brew_pkg::ST_READY;
                end
            end
            brew_pkg::ST_ERROR: begin
                if (!critical_error && flags.retry_done) begin
                    // Reheat only if a brew is possible
                    if (can_make_coffee && paper_filter_present) begin
                        next_state = brew_pkg::ST_HEATING;
                    end else begin
                        next_state = brew_pkg::ST_IDLE;
                    end
                end else if (on_splash) begin
                    next_state = brew_pkg::ST_IDLE;
                end
            end
            brew_pkg::ST_EMERGENCY: begin
                if (!critical_error && flags.retry_done) next_state = brew_pkg::ST_IDLE;
            end
            brew_pkg::ST_COOLDOWN: begin
                if (flags.cooldown_done) next_state = brew_pkg::ST_IDLE;
                else if (!on_splash) next_state = brew_pkg::ST_HEATING;
            end
            // Unknown code, restart
            default: next_state = brew_pkg::ST_INIT;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dwell_timer.sv */
// ==================================================
// State dwell counter and error retry counter
// Dwell count reads 0 in the first cycle of a visit
// Both counters saturate at the TIMER_W maximum
// ==================================================
`default_nettype none

module dwell_timer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [brew_pkg::STATE_W-1:0] state,
    input  wire                         entered,
    dwell_flags_if.timer                flags
);

    logic [brew_pkg::TIMER_W-1:0] dwell_cnt;
    logic [brew_pkg::TIMER_W-1:0] dwell_val;
    logic [brew_pkg::TIMER_W-1:0] retry_cnt;
    logic                         in_fault;

    assign in_fault = (state == brew_pkg::ST_ERROR) || (state == brew_pkg::ST_EMERGENCY);

    // ==================================================
    // Dwell counter
    // ==================================================
    // Register runs one ahead so the entry cycle reads 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
        end else if (entered) begin
            dwell_cnt <= brew_pkg::TIMER_W'(1);
        end else if (dwell_cnt != '1) begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign dwell_val = entered ? '0 : dwell_cnt;

    // Retry counter, zero outside error and emergency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retry_cnt <= '0;
        end else if (!in_fault) begin
            retry_cnt <= '0;
        end else if (retry_cnt != '1) begin
            retry_cnt <= retry_cnt + 1'b1;
        end
    end

    // ==================================================
    // Limit flags
    // ==================================================
    assign flags.init_done     = (dwell_val >= brew_pkg::INIT_CYCLES);
    assign flags.cooldown_done = (dwell_val >= brew_pkg::COOLDOWN_CYCLES);
    assign flags.complete_done = (dwell_val >= brew_pkg::COMPLETE_CYCLES);
    assign flags.retry_done    = (retry_cnt >= brew_pkg::RETRY_CYCLES);

endmodule

`default_nettype wire

/* verilog/status_decoder.sv */
// ==================================================
// Registered actuator and status outputs
// Outputs follow the state by one cycle
// abort_brew may stay high for many cycles while in
// error with an active recipe, or in emergency
// ==================================================
`default_nettype none

module status_decoder (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [brew_pkg::STATE_W-1:0] state,
    input  wire  [brew_pkg::STATE_W-1:0] next_state,
    input  wire                          entered,
    input  wire                          recipe_active,
    output logic                         start_brew,
    output logic                         abort_brew,
    output logic                         heating_enable,
    output logic [brew_pkg::TEMP_W-1:0]  temp_mode,
    output logic                         system_ready,
    output logic                         system_active,
    output logic                         system_fault,
    output logic                         emergency_stop
);

    logic in_brewing;
    logic heat_on;
    logic active_on;
    logic fault_on;
    // Leaving brewing for anything but completion
    logic early_exit;
    logic abort_req;

    assign in_brewing = (state == brew_pkg::ST_BREWING);

    // ==================================================
    // Per-state output pattern
    // ==================================================
    always_comb begin
        heat_on   = 1'b0;
        active_on = 1'b0;
        case (state)
            brew_pkg::ST_INIT,
            brew_pkg::ST_COOLDOWN: begin
                active_on = 1'b1;
            end
            brew_pkg::ST_HEATING,
            brew_pkg::ST_VALIDATE,
            brew_pkg::ST_BREWING: begin
                heat_on   = 1'b1;
                active_on = 1'b1;
            end
            brew_pkg::ST_READY,
            brew_pkg::ST_COMPLETE: begin
                heat_on = 1'b1;
            end
            default: begin
                heat_on   = 1'b0;
                active_on = 1'b0;
            end
        endcase
    end

    assign fault_on = (state == brew_pkg::ST_ERROR) || (state == brew_pkg::ST_EMERGENCY);

    assign early_exit = in_brewing && (next_state != brew_pkg::ST_BREWING) &&
                        (next_state != brew_pkg::ST_COMPLETE);

    // Abort on early exit, errors with a running recipe, always in emergency
    assign abort_req = early_exit || (state == brew_pkg::ST_ERROR && recipe_active) ||
                       (state == brew_pkg::ST_EMERGENCY);

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_brew     <= 1'b0;
            abort_brew     <= 1'b0;
            heating_enable <= 1'b0;
            temp_mode      <= brew_pkg::TEMP_STANDBY;
            system_ready   <= 1'b0;
            system_active  <= 1'b0;
            system_fault   <= 1'b0;
            emergency_stop <= 1'b0;
        end else begin
            // One pulse per brewing visit
            start_brew     <= in_brewing && entered;
            abort_brew     <= abort_req;
            heating_enable <= heat_on;
            temp_mode      <= heat_on ? brew_pkg::TEMP_BREWING : brew_pkg::TEMP_STANDBY;
            system_ready   <= (state == brew_pkg::ST_READY);
            system_active  <= active_on;
            system_fault   <= fault_on;
            emergency_stop <= (state == brew_pkg::ST_EMERGENCY);
        end
    end

endmodule

`default_nettype wire

/* verilog/brew_ctrl_top.sv */
// ==================================================
// Brew machine system controller, top level
// Recipe handshake: start_brew is a one-cycle pulse,
// abort_brew a pulse or a level in fault states
// Status outputs lag the state by one cycle
// All inputs are sampled as levels in the clk domain
// ==================================================
`default_nettype none

module brew_ctrl_top (
    input  wire                          clk,
    input  wire                          rst_n,

    // Menu navigator
    input  wire  [brew_pkg::MENU_W-1:0]  menu_state,
    input  wire                          start_brewing_cmd,

    // Recipe engine
    output logic                         start_brew,
    output logic                         abort_brew,
    input  wire                          recipe_active,
    input  wire                          recipe_complete,
    input  wire                          recipe_valid,

    // Water system
    output logic                         heating_enable,
    output logic [brew_pkg::TEMP_W-1:0]  temp_mode,
    input  wire                          water_system_ok,

    // Consumables and error handler
    input  wire                          can_make_coffee,
    input  wire                          paper_filter_present,
    input  wire                          critical_error,

    // System status
    output logic                         system_ready,
    output logic                         system_active,
    output logic                         system_fault,
    output logic                         emergency_stop
);

    logic [brew_pkg::STATE_W-1:0] state;
    logic [brew_pkg::STATE_W-1:0] next_state;
    logic                         entered;

    // Timer to sequencer flags
    dwell_flags_if flags ();

    // ==================================================
    // State sequencing
    // ==================================================
    brew_sequencer u_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .menu_state           (menu_state),
        .start_brewing_cmd    (start_brewing_cmd),
        .recipe_active        (recipe_active),
        .recipe_complete      (recipe_complete),
        .recipe_valid         (recipe_valid),
        .water_system_ok      (water_system_ok),
        .can_make_coffee      (can_make_coffee),
        .paper_filter_present (paper_filter_present),
        .critical_error       (critical_error),
        .flags                (flags.sequencer),
        .state                (state),
        .next_state           (next_state),
        .entered              (entered)
    );

    // Dwell and retry counters
    dwell_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .entered (entered),
        .flags   (flags.timer)
    );

    // Registered actuator and status outputs
    status_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .next_state     (next_state),
        .entered        (entered),
        .recipe_active  (recipe_active),
        .start_brew     (start_brew),
        .abort_brew     (abort_brew),
        .heating_enable (heating_enable),
        .temp_mode      (temp_mode),
        .system_ready   (system_ready),
        .system_active  (system_active),
        .system_fault   (system_fault),
        .emergency_stop (emergency_stop)
    );

endmodule

`default_nettype wire

/* sim/tb_brew_ctrl.sv */
// ==================================================
// Directed testbench for the brew controller
// Inputs change on the falling edge, and outputs
// are sampled there as well, half a cycle after
// the rising edge that updates them
// Every wait gives up after WAIT_LIMIT cycles
// ==================================================
`default_nettype none

module tb_brew_ctrl;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int WAIT_LIMIT = 300;

    // Output selectors for wait_output
    localparam int SEL_START  = 0;
    localparam int SEL_ABORT  = 1;
    localparam int SEL_HEAT   = 2;
    localparam int SEL_READY  = 3;
    localparam int SEL_ACTIVE = 4;
    localparam int SEL_FAULT  = 5;
    localparam int SEL_EMERG  = 6;

    // Any screen other than splash, brewing or completion
    localparam logic [brew_pkg::MENU_W-1:0] MENU_MAIN = 4'd1;

    logic                         clk;
    logic                         rst_n;
    logic [brew_pkg::MENU_W-1:0]  menu_state;
    logic                         start_brewing_cmd;
    logic                         recipe_active;
    logic                         recipe_complete;
    logic                         recipe_valid;
    logic                         water_system_ok;
    logic                         can_make_coffee;
    logic                         paper_filter_present;
    logic                         critical_error;
    logic                         start_brew;
    logic                         abort_brew;
    logic                         heating_enable;
    logic [brew_pkg::TEMP_W-1:0]  temp_mode;
    logic                         system_ready;
    logic                         system_active;
    logic                         system_fault;
    logic                         emergency_stop;

    int errors;
    int timeouts;
    // Pulse tallies, one sample per falling edge
    int start_cnt;
    int abort_cnt;

    brew_ctrl_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .menu_state           (menu_state),
        .start_brewing_cmd    (start_brewing_cmd),
        .start_brew           (start_brew),
        .abort_brew           (abort_brew),
        .recipe_active        (recipe_active),
        .recipe_complete      (recipe_complete),
        .recipe_valid         (recipe_valid),
        .heating_enable       (heating_enable),
        .temp_mode            (temp_mode),
        .water_system_ok      (water_system_ok),
        .can_make_coffee      (can_make_coffee),
        .paper_filter_present (paper_filter_present),
        .critical_error       (critical_error),
        .system_ready         (system_ready),
        .system_active        (system_active),
        .system_fault         (system_fault),
        .emergency_stop       (emergency_stop)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t ns: %s, expected %0b got %0b", $time, what, expected, actual);
        end
    endtask

    task automatic check_temp(input logic [brew_pkg::TEMP_W-1:0] actual,
                              input logic [brew_pkg::TEMP_W-1:0] expected,
                              input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t ns: %s, expected %0b got %0b", $time, what, expected, actual);
        end
    endtask

    task automatic expect_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            errors++;
            $display("FAIL t=%0t ns: %s, expected %0d got %0d", $time, what, expected, actual);
        end
    endtask

    // ==================================================
    // Cycle stepping and bounded waits
    // ==================================================
    // Advance to the next falling edge and tally pulses
    task automatic next_cycle();
        @(negedge clk);
        if (start_brew === 1'b1) start_cnt++;
        if (abort_brew === 1'b1) abort_cnt++;
    endtask

    task automatic clear_tally();
        start_cnt = 0;
        abort_cnt = 0;
    endtask

    function automatic logic output_bit(input int sel);
        case (sel)
            SEL_START:  return start_brew;
            SEL_ABORT:  return abort_brew;
            SEL_HEAT:   return heating_enable;
            SEL_READY:  return system_ready;
            SEL_ACTIVE: return system_active;
            SEL_FAULT:  return system_fault;
            SEL_EMERG:  return emergency_stop;
            default:    return 1'bx;
        endcase
    endfunction

    // Returns the number of cycles stepped before the level was seen
    task automatic wait_output(input int sel, input logic value, input string what,
                               output int cycles);
        cycles = 0;
        while (output_bit(sel) !== value && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (output_bit(sel) !== value) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        end
    endtask

    // Start command from ready, recipe engine answers start_brew
    task automatic begin_brew();
        int n;
        menu_state        = brew_pkg::MENU_BREWING;
        start_brewing_cmd = 1'b1;
        next_cycle();
        start_brewing_cmd = 1'b0;
        wait_output(SEL_START, 1'b1, "start_brew pulse", n);
        recipe_active = 1'b1;
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic reset_to_idle();
        int n;
        rst_n = 1'b0;
        repeat (5) next_cycle();
        check_bit(start_brew, 1'b0, "start_brew in reset");
        check_bit(abort_brew, 1'b0, "abort_brew in reset");
        check_bit(heating_enable, 1'b0, "heating_enable in reset");
        check_bit(system_ready, 1'b0, "system_ready in reset");
        check_bit(system_active, 1'b0, "system_active in reset");
        check_bit(system_fault, 1'b0, "system_fault in reset");
        check_bit(emergency_stop, 1'b0, "emergency_stop in reset");
        check_temp(temp_mode, brew_pkg::TEMP_STANDBY, "temp_mode in reset");
        repeat (5) next_cycle();
        rst_n = 1'b1;
        // Init is active for its dwell, then idle
        wait_output(SEL_ACTIVE, 1'b1, "system_active rise in init", n);
        wait_output(SEL_ACTIVE, 1'b0, "system_active fall after init", n);
        check_bit(heating_enable, 1'b0, "heating_enable in idle");
        check_bit(system_ready, 1'b0, "system_ready in idle");
        check_temp(temp_mode, brew_pkg::TEMP_STANDBY, "temp_mode in idle");
    endtask

    task automatic wake_to_ready();
        int n;
        menu_state      = MENU_MAIN;
        water_system_ok = 1'b1;
        wait_output(SEL_HEAT, 1'b1, "heating_enable rise on wake-up", n);
        check_temp(temp_mode, brew_pkg::TEMP_BREWING, "temp_mode while heating");
        wait_output(SEL_READY, 1'b1, "system_ready after heating", n);
        check_bit(system_active, 1'b0, "system_active in ready");
        // Back to splash, ready times out into cooldown
        menu_state = brew_pkg::MENU_SPLASH;
        wait_output(SEL_READY, 1'b0, "system_ready fall on splash", n);
        wait_output(SEL_HEAT, 1'b0, "heating_enable fall in cooldown", n);
        check_temp(temp_mode, brew_pkg::TEMP_STANDBY, "temp_mode in cooldown");
        wait_output(SEL_ACTIVE, 1'b0, "system_active fall after cooldown", n);
        check_bit(heating_enable, 1'b0, "heating_enable back in idle");
        // Ready again for the brew tests
        menu_state = MENU_MAIN;
        wait_output(SEL_READY, 1'b1, "system_ready before normal brew", n);
    endtask

    task automatic normal_brew();
        int n;
        recipe_valid         = 1'b1;
        can_make_coffee      = 1'b1;
        paper_filter_present = 1'b1;
        clear_tally();
        begin_brew();
        repeat (4) next_cycle();
        check_bit(system_active, 1'b1, "system_active while brewing");
        check_bit(abort_brew, 1'b0, "abort_brew while brewing");
        // Engine finishes, navigator shows the completion screen
        recipe_complete = 1'b1;
        menu_state      = brew_pkg::MENU_COMPLETE;
        wait_output(SEL_ACTIVE, 1'b0, "system_active fall on completion", n);
        check_bit(heating_enable, 1'b1, "heating_enable in completion");
        check_bit(system_fault, 1'b0, "system_fault in completion");
        recipe_active   = 1'b0;
        recipe_complete = 1'b0;
        next_cycle();
        check_bit(system_ready, 1'b0, "system_ready on completion screen");
        menu_state = MENU_MAIN;
        wait_output(SEL_READY, 1'b1, "system_ready after completion", n);
        expect_count(start_cnt, 1, "start_brew pulses in normal brew");
        expect_count(abort_cnt, 0, "abort_brew pulses in normal brew");
    endtask

    task automatic validation_retry();
        int n;
        paper_filter_present = 1'b0;
        clear_tally();
        start_brewing_cmd = 1'b1;
        next_cycle();
        start_brewing_cmd = 1'b0;
        wait_output(SEL_FAULT, 1'b1, "system_fault after failed validation", n);
        check_bit(heating_enable, 1'b0, "heating_enable in error");
        check_bit(emergency_stop, 1'b0, "emergency_stop in error");
        // Error holds for the retry delay plus its entry cycle
        wait_output(SEL_FAULT, 1'b0, "system_fault clear after retry", n);
        expect_count(n, int'(brew_pkg::RETRY_CYCLES) + 1, "cycles spent in error");
        // Filter missing, so idle rather than heating
        check_bit(heating_enable, 1'b0, "heating_enable after retry");
        check_bit(system_active, 1'b0, "system_active after retry");
        expect_count(start_cnt, 0, "start_brew pulses on failed validation");
        expect_count(abort_cnt, 0, "abort_brew pulses on failed validation");
        paper_filter_present = 1'b1;
        wait_output(SEL_READY, 1'b1, "system_ready after filter refit", n);
    endtask

    task automatic emergency_in_brew();
        int n;
        clear_tally();
        begin_brew();
        repeat (2) next_cycle();
        critical_error = 1'b1;
        wait_output(SEL_EMERG, 1'b1, "emergency_stop on critical error", n);
        check_bit(system_fault, 1'b1, "system_fault in emergency");
        check_bit(abort_brew, 1'b1, "abort_brew in emergency");
        // Engine stops on abort and the error source clears
        recipe_active  = 1'b0;
        critical_error = 1'b0;
        wait_output(SEL_EMERG, 1'b0, "emergency_stop clear after retry", n);
        check_bit(system_fault, 1'b0, "system_fault after emergency");
        check_bit(heating_enable, 1'b0, "heating_enable back in idle");
        check_bit(system_active, 1'b0, "system_active back in idle");
        expect_count(start_cnt, 1, "start_brew pulses before emergency");
        menu_state = MENU_MAIN;
        wait_output(SEL_READY, 1'b1, "system_ready after emergency", n);
    endtask

    task automatic user_cancel();
        int n;
        clear_tally();
        begin_brew();
        repeat (2) next_cycle();
        // User leaves the brewing screen
        menu_state = MENU_MAIN;
        wait_output(SEL_ABORT, 1'b1, "abort_brew on user cancel", n);
        recipe_active = 1'b0;
        wait_output(SEL_READY, 1'b1, "system_ready after cancel", n);
        check_bit(system_fault, 1'b0, "system_fault after cancel");
        next_cycle();
        check_bit(abort_brew, 1'b0, "abort_brew after cancel");
        expect_count(start_cnt, 1, "start_brew pulses in cancel");
        expect_count(abort_cnt, 1, "abort_brew pulses in cancel");
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        errors               = 0;
        timeouts             = 0;
        start_cnt            = 0;
        abort_cnt            = 0;
        clk                  = 1'b0;
        rst_n                = 1'b0;
        menu_state           = brew_pkg::MENU_SPLASH;
        start_brewing_cmd    = 1'b0;
        recipe_active        = 1'b0;
        recipe_complete      = 1'b0;
        recipe_valid         = 1'b0;
        water_system_ok      = 1'b0;
        can_make_coffee      = 1'b0;
        paper_filter_present = 1'b0;
        critical_error       = 1'b0;

        reset_to_idle();
        wake_to_ready();
        normal_brew();
        validation_retry();
        emergency_in_brew();
        user_cancel();

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/brew_pkg.sv
verilog/dwell_flags_if.sv
verilog/brew_sequencer.sv
verilog/dwell_timer.sv
verilog/status_decoder.sv
verilog/brew_ctrl_top.sv
sim/tb_brew_ctrl.sv
